// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_mult_buf
FILELIST   := sim.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: block_counter.sv
`timescale 1ns/1ps

module block_counter #(
    parameter int ADDR_W = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              inc,
    output logic [ADDR_W-1:0] count,
    output logic              last
);

    // ==============================
    // position counter
    // ==============================

    // wraps to zero after the final address
    // clear wins over inc
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count <= '0;
        end else if (inc) begin
            count <= count + 1'b1;
        end
    end

    // ==============================
    // end of block
    // ==============================

    // final address of a block is all ones
    // inc while last marks the event that closes a phase
    assign last = &count;

endmodule

// File: buf_ctrl.sv
`timescale 1ns/1ps

module buf_ctrl #(
    parameter int ADDR_W = 6
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic drain_start,
    input  logic out_ready,
    input  logic acc_last,
    input  logic wr_last,
    input  logic wr_en,
    input  logic rd_last,
    output logic in_ready,
    output logic accept,
    output logic rd_en,
    output logic cnt_clear,
    output logic out_valid,
    output logic full
);

    import mult_buf_pkg::*;

    buf_state_t state_q;
    buf_state_t state_d;

    // final read already issued this drain
    logic rd_done;

    // output beat taken on this edge
    logic beat_xfer;
    logic last_xfer;

    // last-address flags need at least a two-entry block
    if (ADDR_W < 1) begin : g_addr_w_check
        $error("buf_ctrl needs ADDR_W of at least 1");
    end

    // ==============================
    // decoded outputs
    // ==============================

    assign in_ready  = (state_q == FILL);
    assign accept    = in_valid && in_ready;
    assign full      = (state_q == FULL);

    // read when data remains and the output slot is empty or draining
    assign rd_en     = (state_q == DRAIN) && !rd_done && (!out_valid || out_ready);

    assign beat_xfer = out_valid && out_ready;
    assign last_xfer = beat_xfer && rd_done;

    // counters restart once the block has left
    assign cnt_clear = last_xfer;

    // ==============================
    // next state
    // ==============================

    // FLUSH covers the MULT_LATENCY edges until the last product lands
    always_comb begin
        state_d = state_q;
        case (state_q)
            FILL: begin
                if (accept && acc_last) begin
                    state_d = FLUSH;
                end
            end
            FLUSH: begin
                if (wr_en && wr_last) begin
                    state_d = FULL;
                end
            end
            FULL: begin
                if (drain_start) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (last_xfer) begin
                    state_d = FILL;
                end
            end
            default: state_d = FILL;
        endcase
    end

    // ==============================
    // registers
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= FILL;
            out_valid <= 1'b0;
            rd_done   <= 1'b0;
        end else begin
            state_q <= state_d;

            // new beat loads with the read, otherwise drop when taken
            if (rd_en) begin
                out_valid <= 1'b1;
            end else if (beat_xfer) begin
                out_valid <= 1'b0;
            end

            if (last_xfer) begin
                rd_done <= 1'b0;
            end else if (rd_en && rd_last) begin
                rd_done <= 1'b1;
            end
        end
    end

endmodule

// File: digit_mult_pipe.sv
`timescale 1ns/1ps

module digit_mult_pipe (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    input  logic [mult_buf_pkg::OPERAND_W-1:0] in_a,
    input  logic [mult_buf_pkg::OPERAND_W-1:0] in_b,
    output logic                              out_valid,
    output logic [mult_buf_pkg::PRODUCT_W-1:0] product
);

    import mult_buf_pkg::*;

    // register stages between in_valid and out_valid
    localparam int N_STAGES = 8;

    // stage registers, named by the stage that loads them
    logic [OPERAND_W-1:0] a_s1;
    logic [OPERAND_W-1:0] b_s1;
    logic [7:0]           a_hi_s2;
    logic [OPERAND_W-1:0] b_s2;
    logic [7:0]           row01_s2 [0:7];
    logic [7:0]           pp_s3 [0:15];
    logic [PRODUCT_W-1:0] spp_s4 [0:15];
    logic [PRODUCT_W-1:0] lvl1_s5 [0:7];
    logic [PRODUCT_W-1:0] lvl2_s6 [0:3];
    logic [PRODUCT_W-1:0] lvl3_s7 [0:1];
    logic [PRODUCT_W-1:0] sum_s8;

    // valid bit shadowing the data
    logic [N_STAGES-1:0]  vld_sr;

    // ==============================
    // stage 1
    // ==============================

    // capture operands
    always_ff @(posedge clk) begin
        a_s1 <= in_a;
        b_s1 <= in_b;
    end

    // ==============================
    // stages 2 and 3
    // ==============================

    // partial product index k = 4*i + j
    // i is the digit of a, j the digit of b
    // weight of entry k is 2^(4*(i+j))

    // rows 0 and 1 from the low byte of a
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 4; j++) begin
                row01_s2[i*4 + j] <= a_s1[i*4 +: 4] * b_s1[j*4 +: 4];
            end
        end
        // only the high byte of a is still needed
        a_hi_s2 <= a_s1[15:8];
        b_s2    <= b_s1;
    end

    // rows 2 and 3, rows 0 and 1 forwarded to line up
    always_ff @(posedge clk) begin
        for (int k = 0; k < 8; k++) begin
            pp_s3[k] <= row01_s2[k];
        end
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 4; j++) begin
                pp_s3[8 + i*4 + j] <= a_hi_s2[i*4 +: 4] * b_s2[j*4 +: 4];
            end
        end
    end

    // ==============================
    // stage 4
    // ==============================

    // place each 8-bit product at its digit weight
    always_ff @(posedge clk) begin
        for (int k = 0; k < 16; k++) begin
            spp_s4[k] <= PRODUCT_W'(pp_s3[k]) << (4 * (k / 4 + k % 4));
        end
    end

    // ==============================
    // stages 5 to 8
    // ==============================

    // tree level 1, 16 to 8
    always_ff @(posedge clk) begin
        for (int k = 0; k < 8; k++) begin
            lvl1_s5[k] <= spp_s4[2*k] + spp_s4[2*k + 1];
        end
    end

    // tree level 2, 8 to 4
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            lvl2_s6[k] <= lvl1_s5[2*k] + lvl1_s5[2*k + 1];
        end
    end

    // tree level 3, 4 to 2
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            lvl3_s7[k] <= lvl2_s6[2*k] + lvl2_s6[2*k + 1];
        end
    end

    // final sum, cannot overflow 32 bits for 16x16 unsigned
    always_ff @(posedge clk) begin
        sum_s8 <= lvl3_s7[0] + lvl3_s7[1];
    end

    assign product = sum_s8;

    // ==============================
    // valid chain
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[N_STAGES-2:0], in_valid};
        end
    end

    assign out_valid = vld_sr[N_STAGES-1];

endmodule

// File: mult_buf_assert.sv
`timescale 1ns/1ps

module mult_buf_assert (
    input logic                               clk,
    input logic                               rst,
    input logic                               in_ready,
    input logic                               out_valid,
    input logic                               out_ready,
    input logic [mult_buf_pkg::PRODUCT_W-1:0] out_data,
    input logic                               full
);

    import mult_buf_pkg::*;

    // ==============================
    // output stream
    // ==============================

    // stalled beat keeps its data and stays offered
    a_data_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("out_data or out_valid changed under back-pressure");

    // ==============================
    // phase rules
    // ==============================

    // filling and draining never overlap
    a_fill_drain: assert property (@(posedge clk) disable iff (rst)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid high together");

    // full only rises once the last accepted pair has left the pipeline
    // in_ready already low MULT_LATENCY samples earlier
    a_full_ready: assert property (@(posedge clk) disable iff (rst)
        $rose(full) |-> $past(!in_ready, MULT_LATENCY))
        else $error("full rose before the last product could be written");

endmodule

bind mult_buf_top mult_buf_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .full     (full)
);

// File: mult_buf_pkg.sv
package mult_buf_pkg;

    // ==============================
    // widths
    // ==============================

    // operand width is tied to the 4x4 digit split in the pipeline
    localparam int OPERAND_W = 16;

    // full unsigned product of two operands
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // ==============================
    // timing
    // ==============================

    // edges from an accepted operand pair to its product write
    localparam int MULT_LATENCY = 8;

    // ==============================
    // controller phases
    // ==============================

    // FILL   taking operands
    // FLUSH  last pair accepted, products still in flight
    // FULL   whole block stored, waiting on drain request
    // DRAIN  streaming the block out
    typedef enum logic [1:0] {
        FILL  = 2'd0,
        FLUSH = 2'd1,
        FULL  = 2'd2,
        DRAIN = 2'd3
    } buf_state_t;

endpackage

// File: mult_buf_top.sv
`timescale 1ns/1ps

module mult_buf_top #(
    parameter int ADDR_W = 6
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [mult_buf_pkg::OPERAND_W-1:0] in_a,
    input  logic [mult_buf_pkg::OPERAND_W-1:0] in_b,
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic [mult_buf_pkg::PRODUCT_W-1:0] out_data,
    input  logic                               drain_start,
    output logic                               full
);

    import mult_buf_pkg::*;

    // handshake and sequencing
    logic accept;
    logic rd_en;
    logic cnt_clear;

    // multiplier result
    logic                 prod_valid;
    logic [PRODUCT_W-1:0] product;

    // block positions
    logic              acc_last;
    logic              wr_last;
    logic              rd_last;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // ==============================
    // control
    // ==============================

    buf_ctrl #(
        .ADDR_W(ADDR_W)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .drain_start(drain_start),
        .out_ready  (out_ready),
        .acc_last   (acc_last),
        .wr_last    (wr_last),
        .wr_en      (prod_valid),
        .rd_last    (rd_last),
        .in_ready   (in_ready),
        .accept     (accept),
        .rd_en      (rd_en),
        .cnt_clear  (cnt_clear),
        .out_valid  (out_valid),
        .full       (full)
    );

    // ==============================
    // datapath
    // ==============================

    // accept doubles as the pipeline valid bit
    digit_mult_pipe u_mult (
        .clk      (clk),
        .rst      (rst),
        .in_valid (accept),
        .in_a     (in_a),
        .in_b     (in_b),
        .out_valid(prod_valid),
        .product  (product)
    );

    // accept position, only the end flag matters
    block_counter #(
        .ADDR_W(ADDR_W)
    ) u_acc_cnt (
        .clk  (clk),
        .rst  (rst),
        .clear(cnt_clear),
        .inc  (accept),
        .count(),
        .last (acc_last)
    );

    // write address follows products out of the pipeline
    block_counter #(
        .ADDR_W(ADDR_W)
    ) u_wr_cnt (
        .clk  (clk),
        .rst  (rst),
        .clear(cnt_clear),
        .inc  (prod_valid),
        .count(wr_addr),
        .last (wr_last)
    );

    // read address steps with each issued read
    block_counter #(
        .ADDR_W(ADDR_W)
    ) u_rd_cnt (
        .clk  (clk),
        .rst  (rst),
        .clear(cnt_clear),
        .inc  (rd_en),
        .count(rd_addr),
        .last (rd_last)
    );

    product_ram #(
        .ADDR_W(ADDR_W)
    ) u_ram (
        .clk    (clk),
        .wr_en  (prod_valid),
        .wr_addr(wr_addr),
        .wr_data(product),
        .rd_en  (rd_en),
        .rd_addr(rd_addr),
        .rd_data(out_data)
    );

endmodule

// File: product_ram.sv
`timescale 1ns/1ps

module product_ram #(
    parameter int ADDR_W = 6
) (
    input  logic                               clk,
    input  logic                               wr_en,
    input  logic [ADDR_W-1:0]                  wr_addr,
    input  logic [mult_buf_pkg::PRODUCT_W-1:0] wr_data,
    input  logic                               rd_en,
    input  logic [ADDR_W-1:0]                  rd_addr,
    output logic [mult_buf_pkg::PRODUCT_W-1:0] rd_data
);

    import mult_buf_pkg::*;

    // one block of products
    logic [PRODUCT_W-1:0] mem [0:(1 << ADDR_W) - 1];

    // write port, fed straight from the multiplier
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read register
    // holds while rd_en is low so the output beat stays put
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: sim.f
mult_buf_pkg.sv
digit_mult_pipe.sv
block_counter.sv
product_ram.sv
buf_ctrl.sv
mult_buf_top.sv
mult_buf_assert.sv
tb_mult_buf.sv

// File: tb_mult_buf.sv
`timescale 1ns/1ps

module tb_mult_buf;

    import mult_buf_pkg::*;

    // small blocks keep the run short
    localparam int ADDR_W      = 4;
    localparam int BLOCK       = 1 << ADDR_W;
    localparam int N_ROWS      = 2 * BLOCK;
    localparam int RST_CYCLES  = 5;
    localparam int WAIT_LIMIT  = 100;
    localparam int TAIL_CYCLES = 24;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    logic [OPERAND_W-1:0] in_a;
    logic [OPERAND_W-1:0] in_b;
    logic                 out_valid;
    logic                 out_ready;
    logic [PRODUCT_W-1:0] out_data;
    logic                 drain_start;
    logic                 full;

    // operand table and expected products
    logic [OPERAND_W-1:0] tab_a [0:N_ROWS-1];
    logic [OPERAND_W-1:0] tab_b [0:N_ROWS-1];
    logic [PRODUCT_W-1:0] exp_p [0:N_ROWS-1];

    logic [31:0] lfsr = 32'hc626_3982;

    always #20 clk = ~clk;

    mult_buf_top #(
        .ADDR_W(ADDR_W)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .drain_start(drain_start),
        .full       (full)
    );

    // ==============================
    // random source
    // ==============================

    // galois form, one step per bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val = {val[30:0], lfsr_bit()};
        end
        return val;
    endfunction

    // ==============================
    // checking
    // ==============================

    task automatic fail_stop();
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %08h actual %08h", name, expected, actual);
            fail_stop();
        end
    endtask

    // ==============================
    // operand table
    // ==============================

    task automatic set_row(input int idx, input logic [15:0] a, input logic [15:0] b);
        tab_a[idx] = a;
        tab_b[idx] = b;
    endtask

    task automatic build_table();
        for (int i = 0; i < N_ROWS; i++) begin
            tab_a[i] = 16'(lfsr_bits(16));
            tab_b[i] = 16'(lfsr_bits(16));
        end
        // corners, zero and one
        set_row(0, 16'h0000, 16'h1234);
        set_row(1, 16'habcd, 16'h0000);
        set_row(2, 16'h0001, 16'hbeef);
        set_row(3, 16'hffff, 16'h0001);
        // largest product and a carry into the top bit
        set_row(4, 16'hffff, 16'hffff);
        set_row(5, 16'h8000, 16'h0002);
        // digit boundaries
        set_row(6, 16'h000f, 16'h00f0);
        set_row(7, 16'h0f00, 16'hf000);
        set_row(8, 16'h00ff, 16'hff00);
        set_row(9, 16'hf0f0, 16'h0f0f);
        set_row(BLOCK, 16'hffff, 16'hfffe);
        set_row(BLOCK + 1, 16'h0010, 16'h1000);
        set_row(N_ROWS - 1, 16'hffff, 16'hffff);
        // plain unsigned product
        for (int i = 0; i < N_ROWS; i++) begin
            exp_p[i] = 32'(tab_a[i]) * 32'(tab_b[i]);
        end
    endtask

    // ==============================
    // sequences
    // ==============================

    task automatic apply_reset();
        rst         <= 1'b1;
        in_valid    <= 1'b0;
        drain_start <= 1'b0;
        out_ready   <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    // offers rows with random idle gaps, returns on the last transfer edge
    // drain_start rides along with row pulse_at, must be ignored in FILL
    task automatic fill_rows(input int base, input int count, input int pulse_at);
        int gap;
        int waited;
        for (int i = 0; i < count; i++) begin
            gap = int'(lfsr_bits(2));
            repeat (gap) begin
                @(posedge clk);
                in_valid    <= 1'b0;
                drain_start <= 1'b0;
            end
            @(posedge clk);
            in_valid    <= 1'b1;
            in_a        <= tab_a[base + i];
            in_b        <= tab_b[base + i];
            drain_start <= (i == pulse_at);
            waited = 0;
            @(negedge clk);
            while (!in_ready) begin
                if (waited == WAIT_LIMIT) begin
                    $display("timeout waiting for in_ready on row %0d", base + i);
                    fail_stop();
                end
                waited++;
                @(negedge clk);
            end
            check_value($sformatf("out_valid low in fill row %0d", base + i),
                        32'd0, 32'(out_valid));
            check_value($sformatf("full low in fill row %0d", base + i),
                        32'd0, 32'(full));
        end
        @(posedge clk);
        drain_start <= 1'b0;
    endtask

    // keep offering a pair, none may be taken until the block drains
    task automatic hold_until_full();
        int waited;
        waited = 0;
        in_valid <= 1'b1;
        in_a     <= 16'hdead;
        in_b     <= 16'hbeef;
        @(negedge clk);
        while (!full) begin
            check_value("in_ready low after block", 32'd0, 32'(in_ready));
            if (waited == WAIT_LIMIT) begin
                $display("timeout waiting for full after a complete block");
                fail_stop();
            end
            waited++;
            @(negedge clk);
        end
        check_value("in_ready low while full", 32'd0, 32'(in_ready));
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // beats counted at negedge, transfer lands on the next rising edge
    task automatic drain_block(input int base);
        int beats;
        int idle;
        beats = 0;
        idle  = 0;
        @(posedge clk);
        drain_start <= 1'b1;
        out_ready   <= lfsr_bit();
        @(posedge clk);
        drain_start <= 1'b0;
        while (beats < BLOCK) begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_value($sformatf("beat %0d of row %0d", beats, base + beats),
                            exp_p[base + beats], out_data);
                beats++;
                idle = 0;
            end else if (idle == WAIT_LIMIT) begin
                $display("timeout waiting for output beat %0d", beats);
                fail_stop();
            end else begin
                idle++;
            end
            @(posedge clk);
            // ready about three quarters of the time
            out_ready <= (lfsr_bits(2) != 32'd0);
        end
        out_ready <= 1'b1;
        @(negedge clk);
        check_value("in_ready back after drain", 32'd1, 32'(in_ready));
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            check_value("no beat past end of block", 32'd0, 32'(out_valid));
        end
        @(posedge clk);
        out_ready <= 1'b0;
    endtask

    // ==============================
    // main
    // ==============================

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_a        = '0;
        in_b        = '0;
        out_ready   = 1'b0;
        drain_start = 1'b0;
        build_table();
        apply_reset();

        // first block, stray drain request mid-fill
        fill_rows(0, BLOCK, 5);
        hold_until_full();
        drain_block(0);

        // second block right after the drain
        fill_rows(BLOCK, BLOCK, -1);
        hold_until_full();
        drain_block(BLOCK);

        // reset with a partial block and products in flight
        fill_rows(BLOCK, 7, -1);
        apply_reset();
        @(negedge clk);
        check_value("in_ready after reset", 32'd1, 32'(in_ready));
        check_value("out_valid after reset", 32'd0, 32'(out_valid));
        check_value("full after reset", 32'd0, 32'(full));

        // only the post-reset block may come out
        // memory still holds the second block's products
        fill_rows(0, BLOCK, -1);
        hold_until_full();
        drain_block(0);

        $display("All tests passed!");
        $finish;
    end

endmodule
